// ==== hw/div_pkg.sv ====
package div_pkg;

    // Data path width of the core and the width of the W operations
    parameter int unsigned xlen      = 64;
    parameter int unsigned wlen      = 32;
    parameter int unsigned tag_width = 5;

    // Values follow funct3 of the M extension divide group
    typedef enum logic [2:0] {
        op_div  = 3'b100,
        op_divu = 3'b101,
        op_rem  = 3'b110,
        op_remu = 3'b111
    } div_op_e;

    // Everything the writeback stage needs besides the raw quotient and remainder
    typedef struct packed {
        logic [tag_width-1:0] rd;
        logic                 want_rem;
        logic                 word;
        logic                 div_zero;
        logic                 sign_ovf;
        logic [xlen-1:0]      dividend;
    } div_meta_t;

endpackage

// ==== hw/div_req_if.sv ====
`timescale 1ns/10ps

interface div_req_if import div_pkg::*; ();

    logic            valid;
    logic            is_signed;
    logic            word;
    logic [xlen-1:0] dividend;
    logic [xlen-1:0] divisor;
    div_meta_t       meta;

    modport src (
        output valid, is_signed, word, dividend, divisor, meta
    );

    modport dst (
        input valid, is_signed, word, dividend, divisor, meta
    );

endinterface

// ==== hw/div_rsp_if.sv ====
`timescale 1ns/10ps

interface div_rsp_if import div_pkg::*; ();

    logic            valid;
    logic [xlen-1:0] quotient;
    logic [xlen-1:0] remainder;
    div_meta_t       meta;

    modport src (
        output valid, quotient, remainder, meta
    );

    modport dst (
        input valid, quotient, remainder, meta
    );

endinterface

// ==== hw/div_issue.sv ====
`timescale 1ns/10ps

module div_issue import div_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  div_op_e              req_op,
    input  logic                 req_word,
    input  logic [tag_width-1:0] req_rd,
    input  logic [xlen-1:0]      req_rs1,
    input  logic [xlen-1:0]      req_rs2,
    div_req_if.src               req
);

    logic is_signed;
    logic want_rem;
    logic div_zero;
    logic sign_ovf;

    always_comb begin
        is_signed = (req_op == op_div) || (req_op == op_rem);
        want_rem  = (req_op == op_rem) || (req_op == op_remu);
        // W forms only look at the low half of both operands
        if (req_word) begin
            div_zero = (req_rs2[wlen-1:0] == '0);
            sign_ovf = is_signed
                && (req_rs1[wlen-1:0] == {1'b1, {(wlen-1){1'b0}}})
                && (&req_rs2[wlen-1:0]);
        end else begin
            div_zero = (req_rs2 == '0);
            sign_ovf = is_signed
                && (req_rs1 == {1'b1, {(xlen-1){1'b0}}})
                && (&req_rs2);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            req.is_signed     <= is_signed;
            req.word          <= req_word;
            req.dividend      <= req_rs1;
            req.divisor       <= req_rs2;
            req.meta.rd       <= req_rd;
            req.meta.want_rem <= want_rem;
            req.meta.word     <= req_word;
            req.meta.div_zero <= div_zero;
            req.meta.sign_ovf <= sign_ovf;
            req.meta.dividend <= req_rs1;
        end
    end

endmodule

// ==== hw/div_req_fifo.sv ====
`timescale 1ns/10ps

module div_req_fifo import div_pkg::*; #(
    parameter int unsigned fifo_depth = 4
) (
    input  logic   clk,
    input  logic   rst,
    div_req_if.dst wr,
    div_req_if.src rd,
    input  logic   core_idle,
    output logic   full,
    output logic   overflow_err
);

    localparam int unsigned ptr_w = $clog2(fifo_depth);

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic [ptr_w:0]   count_next;
    logic             push;
    logic             pop;

    logic             sgn_mem  [fifo_depth];
    logic             word_mem [fifo_depth];
    logic [xlen-1:0]  dvd_mem  [fifo_depth];
    logic [xlen-1:0]  dvs_mem  [fifo_depth];
    div_meta_t        meta_mem [fifo_depth];

    // Writes against a full buffer are lost, the caller was told via full
    assign push = wr.valid & ~full;
    assign pop  = (count != '0) & core_idle;

    always_comb begin
        case ({push, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            full         <= 1'b0;
            overflow_err <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count        <= count_next;
            full         <= (count_next == (ptr_w+1)'(fifo_depth));
            overflow_err <= overflow_err | (wr.valid & full);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            sgn_mem[wr_ptr]  <= wr.is_signed;
            word_mem[wr_ptr] <= wr.word;
            dvd_mem[wr_ptr]  <= wr.dividend;
            dvs_mem[wr_ptr]  <= wr.divisor;
            meta_mem[wr_ptr] <= wr.meta;
        end
    end

    // Head is shown ahead, the strobe doubles as the pop
    assign rd.valid     = pop;
    assign rd.is_signed = sgn_mem[rd_ptr];
    assign rd.word      = word_mem[rd_ptr];
    assign rd.dividend  = dvd_mem[rd_ptr];
    assign rd.divisor   = dvs_mem[rd_ptr];
    assign rd.meta      = meta_mem[rd_ptr];

endmodule

// ==== hw/div_core.sv ====
`timescale 1ns/10ps

module div_core import div_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    div_req_if.dst req,
    output logic   idle,
    div_rsp_if.src rsp
);

    logic            busy;
    logic            done;
    logic [6:0]      cnt;
    logic [6:0]      last_step;
    logic            accept;
    logic            step;
    logic            finish;

    logic            sgn_dvd;
    logic            sgn_dvs;
    logic [xlen-1:0] abs_dvd;
    logic [xlen-1:0] abs_dvs;

    logic            word_q;
    logic            neg_q;
    logic            neg_r;
    logic [xlen-1:0] quo_sr;
    logic [xlen-1:0] part_rem;
    logic [xlen-1:0] dvs_q;
    div_meta_t       meta_q;
    logic [xlen:0]   trial;

    logic [wlen-1:0] quo_w;
    logic [wlen-1:0] rem_w;
    logic [xlen-1:0] quo_fix;
    logic [xlen-1:0] rem_fix;
    logic [xlen-1:0] quo_out;
    logic [xlen-1:0] rem_out;

    // ##################################################################
    // Operand preparation at acceptance
    // ##################################################################

    assign accept = req.valid & ~busy;
    assign idle   = ~busy;

    always_comb begin
        if (req.word) begin
            sgn_dvd = req.is_signed & req.dividend[wlen-1];
            sgn_dvs = req.is_signed & req.divisor[wlen-1];
            // Word dividend sits in the upper half so its MSB leaves first
            abs_dvd = {sgn_dvd ? -req.dividend[wlen-1:0] : req.dividend[wlen-1:0],
                       {(xlen-wlen){1'b0}}};
            abs_dvs = {{(xlen-wlen){1'b0}},
                       sgn_dvs ? -req.divisor[wlen-1:0] : req.divisor[wlen-1:0]};
        end else begin
            sgn_dvd = req.is_signed & req.dividend[xlen-1];
            sgn_dvs = req.is_signed & req.divisor[xlen-1];
            abs_dvd = sgn_dvd ? -req.dividend : req.dividend;
            abs_dvs = sgn_dvs ? -req.divisor : req.divisor;
        end
    end

    // ##################################################################
    // Step control
    // ##################################################################

    assign last_step = word_q ? 7'd32 : 7'd64;
    assign step      = busy & ~done & (cnt != last_step);
    assign finish    = busy & ~done & (cnt == last_step);

    // busy stays up through the result cycle so idle returns one cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (done) begin
                busy <= 1'b0;
            end else if (finish) begin
                done <= 1'b1;
            end else if (step) begin
                cnt <= cnt + 7'd1;
            end
        end
    end

    // ##################################################################
    // Restoring subtract and shift
    // ##################################################################

    // Next dividend bit joins the partial remainder before the trial subtract
    assign trial = {part_rem, quo_sr[xlen-1]} - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (accept) begin
            quo_sr   <= abs_dvd;
            part_rem <= '0;
            dvs_q    <= abs_dvs;
            word_q   <= req.word;
            neg_q    <= sgn_dvd ^ sgn_dvs;
            neg_r    <= sgn_dvd;
            meta_q   <= req.meta;
        end else if (step) begin
            if (!trial[xlen]) begin
                part_rem <= trial[xlen-1:0];
                quo_sr   <= {quo_sr[xlen-2:0], 1'b1};
            end else begin
                part_rem <= {part_rem[xlen-2:0], quo_sr[xlen-1]};
                quo_sr   <= {quo_sr[xlen-2:0], 1'b0};
            end
        end
    end

    // Signs follow the C rule where the remainder takes the sign of the dividend
    always_comb begin
        quo_w = neg_q ? -quo_sr[wlen-1:0] : quo_sr[wlen-1:0];
        rem_w = neg_r ? -part_rem[wlen-1:0] : part_rem[wlen-1:0];
        if (word_q) begin
            quo_fix = {{(xlen-wlen){1'b0}}, quo_w};
            rem_fix = {{(xlen-wlen){1'b0}}, rem_w};
        end else begin
            quo_fix = neg_q ? -quo_sr : quo_sr;
            rem_fix = neg_r ? -part_rem : part_rem;
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            quo_out <= quo_fix;
            rem_out <= rem_fix;
        end
    end

    assign rsp.valid     = done;
    assign rsp.quotient  = quo_out;
    assign rsp.remainder = rem_out;
    assign rsp.meta      = meta_q;

endmodule

// ==== hw/div_writeback.sv ====
`timescale 1ns/10ps

module div_writeback import div_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    div_rsp_if.dst               rsp,
    output logic                 rsp_valid,
    output logic [tag_width-1:0] rsp_rd,
    output logic [xlen-1:0]      rsp_data
);

    logic [xlen-1:0] quo_sel;
    logic [xlen-1:0] rem_sel;
    logic [xlen-1:0] res;

    always_comb begin
        // Special results defined by the ISA override whatever the divider produced
        if (rsp.meta.div_zero) begin
            quo_sel = '1;
            rem_sel = rsp.meta.dividend;
        end else if (rsp.meta.sign_ovf) begin
            quo_sel = rsp.meta.dividend;
            rem_sel = '0;
        end else begin
            quo_sel = rsp.quotient;
            rem_sel = rsp.remainder;
        end

        res = rsp.meta.want_rem ? rem_sel : quo_sel;

        // All W results are sign extended from bit 31, unsigned ones too
        if (rsp.meta.word) begin
            res = {{(xlen-wlen){res[wlen-1]}}, res[wlen-1:0]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rsp.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.valid) begin
            rsp_rd   <= rsp.meta.rd;
            rsp_data <= res;
        end
    end

endmodule

// ==== hw/div_unit.sv ====
`timescale 1ns/10ps

module div_unit import div_pkg::*; #(
    parameter int unsigned fifo_depth = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  div_op_e              req_op,
    input  logic                 req_word,
    input  logic [tag_width-1:0] req_rd,
    input  logic [xlen-1:0]      req_rs1,
    input  logic [xlen-1:0]      req_rs2,
    output logic                 full,
    output logic                 overflow_err,
    output logic                 rsp_valid,
    output logic [tag_width-1:0] rsp_rd,
    output logic [xlen-1:0]      rsp_data
);

    logic core_idle;

    div_req_if issue_req ();
    div_req_if core_req ();
    div_rsp_if core_rsp ();

    div_issue u_issue (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_word  (req_word),
        .req_rd    (req_rd),
        .req_rs1   (req_rs1),
        .req_rs2   (req_rs2),
        .req       (issue_req.src)
    );

    div_req_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk          (clk),
        .rst          (rst),
        .wr           (issue_req.dst),
        .rd           (core_req.src),
        .core_idle    (core_idle),
        .full         (full),
        .overflow_err (overflow_err)
    );

    div_core u_core (
        .clk  (clk),
        .rst  (rst),
        .req  (core_req.dst),
        .idle (core_idle),
        .rsp  (core_rsp.src)
    );

    div_writeback u_writeback (
        .clk       (clk),
        .rst       (rst),
        .rsp       (core_rsp.dst),
        .rsp_valid (rsp_valid),
        .rsp_rd    (rsp_rd),
        .rsp_data  (rsp_data)
    );

endmodule

// ==== tb/tb_div_unit.sv ====
`timescale 1ns/10ps

module tb_div_unit import div_pkg::*; ();

    localparam int unsigned fifo_depth = 4;
    localparam int full_limit  = 200;
    localparam int drain_limit = 1000;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 req_valid;
    div_op_e              req_op;
    logic                 req_word;
    logic [tag_width-1:0] req_rd;
    logic [xlen-1:0]      req_rs1;
    logic [xlen-1:0]      req_rs2;
    logic                 full;
    logic                 overflow_err;
    logic                 rsp_valid;
    logic [tag_width-1:0] rsp_rd;
    logic [xlen-1:0]      rsp_data;

    logic [tag_width-1:0] exp_rd_q[$];
    logic [xlen-1:0]      exp_data_q[$];
    logic [tag_width-1:0] next_rd;
    int                   cycle = 0;
    int                   strobe_cycle;
    int                   rsp_cycle;
    integer               seed;

    div_unit #(.fifo_depth(fifo_depth)) UUT (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_op(req_op), .req_word(req_word),
        .req_rd(req_rd), .req_rs1(req_rs1), .req_rs2(req_rs2), .full(full),
        .overflow_err(overflow_err), .rsp_valid(rsp_valid), .rsp_rd(rsp_rd), .rsp_data(rsp_data)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input logic [xlen-1:0] actual, input logic [xlen-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // RISC-V M extension divide result with W forms sign extended from bit 31
    function automatic logic [xlen-1:0] ref_div(input div_op_e op, input logic word,
                                                input logic [xlen-1:0] rs1,
                                                input logic [xlen-1:0] rs2);
        logic               sgn;
        logic               rem;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] wa;
        logic signed [31:0] wb;
        logic [63:0]        q;
        logic [63:0]        r;
        logic [31:0]        wq;
        logic [31:0]        wrm;
        sgn = (op == op_div) || (op == op_rem);
        rem = (op == op_rem) || (op == op_remu);
        if (word) begin
            wa = rs1[31:0];
            wb = rs2[31:0];
            if (wb == 0) begin
                wq  = '1;
                wrm = wa;
            end else if (sgn && wa == 32'h8000_0000 && wb == -1) begin
                wq  = wa;
                wrm = '0;
            end else if (sgn) begin
                wq  = wa / wb;
                wrm = wa % wb;
            end else begin
                wq  = rs1[31:0] / rs2[31:0];
                wrm = rs1[31:0] % rs2[31:0];
            end
            wq = rem ? wrm : wq;
            return {{32{wq[31]}}, wq};
        end
        sa = rs1;
        sb = rs2;
        if (sb == 0) begin
            q = '1;
            r = rs1;
        end else if (sgn && sa == 64'h8000_0000_0000_0000 && sb == -1) begin
            q = rs1;
            r = '0;
        end else if (sgn) begin
            q = sa / sb;
            r = sa % sb;
        end else begin
            q = rs1 / rs2;
            r = rs1 % rs2;
        end
        return rem ? r : q;
    endfunction

    // Responses are sampled on the falling edge and must match the oldest request
    always @(negedge clk) begin : compare_responses
        logic [tag_width-1:0] exp_rd;
        logic [xlen-1:0]      exp_data;
        if (!rst && rsp_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("A response for rd %0d arrived with no request outstanding", rsp_rd);
                abort_run();
            end else begin
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                check_value(64'(rsp_rd), 64'(exp_rd), "response tag");
                check_value(rsp_data, exp_data, "response data");
                rsp_cycle = cycle;
            end
        end
    end

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    // Called on a falling edge and returns on the next one with the strobe dropped
    task automatic issue(input div_op_e op, input logic word, input logic [xlen-1:0] rs1,
                         input logic [xlen-1:0] rs2, input logic accepted);
        req_valid = 1'b1;
        req_op    = op;
        req_word  = word;
        req_rd    = next_rd;
        req_rs1   = rs1;
        req_rs2   = rs2;
        if (accepted) begin
            exp_rd_q.push_back(next_rd);
            exp_data_q.push_back(ref_div(op, word, rs1, rs2));
        end
        // The strobe is sampled at the next rising edge
        strobe_cycle = cycle + 1;
        next_rd      = next_rd + 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_not_full();
        int n;
        n = 0;
        while (full) begin
            if (n == full_limit) begin
                $display("Timed out waiting for the request FIFO to leave the full state");
                abort_run();
            end
            n++;
            @(negedge clk);
        end
    endtask

    // The issue register adds one entry in flight, so a gap cycle keeps the FIFO safe
    task automatic send_legal(input div_op_e op, input logic word, input logic [xlen-1:0] rs1,
                              input logic [xlen-1:0] rs2);
        wait_not_full();
        check_value(64'(overflow_err), 64'd0, "overflow_err during legal traffic");
        issue(op, word, rs1, rs2, 1'b1);
        @(negedge clk);
    endtask

    task automatic test_pair(input logic word, input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        send_legal(op_div, word, a, b);
        send_legal(op_divu, word, a, b);
        send_legal(op_rem, word, a, b);
        send_legal(op_remu, word, a, b);
    endtask

    task automatic wait_drain(input logic ovf_expect);
        int n;
        n = 0;
        @(posedge clk);
        while (exp_rd_q.size() != 0) begin
            if (n == drain_limit) begin
                $display("Timed out waiting for %0d outstanding responses", exp_rd_q.size());
                abort_run();
            end
            n++;
            @(negedge clk);
            check_value(64'(overflow_err), 64'(ovf_expect), "overflow_err while draining");
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic check_latency(input logic word, input int expected);
        int start;
        send_legal(op_divu, word, 64'd1000, 64'd9);
        start = strobe_cycle;
        wait_drain(1'b0);
        check_value(64'(rsp_cycle - start), 64'(expected), "idle latency in cycles");
    endtask

    initial begin : main
        int          n;
        logic [31:0] r;
        logic [63:0] a;
        logic [63:0] b;
        seed      = 73;
        next_rd   = '0;
        req_valid = 1'b0;
        req_op    = op_div;
        req_word  = 1'b0;
        req_rd    = '0;
        req_rs1   = '0;
        req_rs2   = '0;
        apply_reset();
        check_value(64'(full), 64'd0, "full after reset");

        // ##################################################################
        // Directed operands, 64 bit, word, then the special cases
        // ##################################################################
        test_pair(1'b0, 64'd100, 64'd7);
        test_pair(1'b0, -64'd100, 64'd7);
        test_pair(1'b0, 64'd100, -64'd7);
        test_pair(1'b0, -64'd100, -64'd7);
        test_pair(1'b0, 64'd7, 64'd100);
        test_pair(1'b0, 64'd12345, 64'd12345);
        test_pair(1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 64'd3);
        test_pair(1'b0, 64'h7FFF_FFFF_FFFF_FFFF, 64'h1_0000_0001);
        wait_drain(1'b0);
        test_pair(1'b1, 64'hDEAD_BEEF_0000_0064, 64'h1234_5678_0000_0007);
        test_pair(1'b1, 64'h0000_0000_FFFF_FF9C, 64'hFFFF_FFFF_FFFF_FFF9);
        test_pair(1'b1, 64'h0000_0000_FFFF_FFF0, 64'hABCD_0000_0000_0001);
        test_pair(1'b1, 64'h5555_0000_FFFF_FFFE, 64'h0000_0000_FFFF_FFFF);
        wait_drain(1'b0);
        test_pair(1'b0, 64'd1234, 64'd0);
        test_pair(1'b1, 64'hAAAA_AAAA_8765_4321, 64'hFFFF_FFFF_0000_0000);
        test_pair(1'b0, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
        test_pair(1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF);
        wait_drain(1'b0);
        check_latency(1'b0, 68);
        check_latency(1'b1, 36);

        // Random burst with zero, minus one and small divisors mixed in
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)};
            if (r[4:2] == 3'd0) b = '0;
            else if (r[4:2] == 3'd1) b = '1;
            else if (r[4:2] == 3'd2) b = b & 64'hFF;
            if (r[6:5] == 2'd0) a = r[7] ? {a[63:32], 32'h8000_0000} : 64'h8000_0000_0000_0000;
            send_legal(div_op_e'({1'b1, r[1:0]}), r[7], a, b);
        end
        wait_drain(1'b0);

        // One request reaches the core and fifo_depth fill the FIFO, so the last one is lost
        for (int i = 0; i < int'(fifo_depth) + 2; i++) begin
            issue(op_divu, 1'b0, 64'(i * 1000 + 5), 64'd3, i <= int'(fifo_depth));
        end
        n = 0;
        while (!overflow_err) begin
            if (n == 10) begin
                $display("overflow_err did not rise after the FIFO was overrun");
                abort_run();
            end
            n++;
            @(negedge clk);
        end
        wait_drain(1'b1);

        // Fill the FIFO again so that reset has to clear full with work in flight
        for (int i = 0; i <= int'(fifo_depth); i++) begin
            issue(op_div, 1'b0, 64'(i * 77 + 1), 64'd5, 1'b0);
        end
        n = 0;
        while (!full) begin
            if (n == 10) begin
                $display("full did not rise after the request FIFO was filled");
                abort_run();
            end
            n++;
            @(negedge clk);
        end
        apply_reset();
        check_value(64'(overflow_err), 64'd0, "overflow_err after reset");
        check_value(64'(full), 64'd0, "full after reset");
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== build.f ====
hw/div_pkg.sv
hw/div_req_if.sv
hw/div_rsp_if.sv
hw/div_issue.sv
hw/div_req_fifo.sv
hw/div_core.sv
hw/div_writeback.sv
hw/div_unit.sv
tb/tb_div_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the divide unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 -f build.f --top-module tb_div_unit -o tb_div_unit
./obj_dir/tb_div_unit
